//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbCore
FILELIST  ?= project.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"
	@echo "Override: VERILATOR TOP FILELIST OBJDIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG) || ! grep -q "Simulation passed" $(LOG); then \
		echo "test FAILED, see $(LOG)"; \
		exit 1; \
	fi
	@echo "test PASSED"

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- project.f
src/isaPkg.sv
src/coreCtrlPkg.sv
src/fetchUnit.sv
src/controlUnit.sv
src/regFile.sv
src/alu.sv
src/memStage.sv
src/mipsCore.sv
tb/tbCore.sv

//--- src/alu.sv
`timescale 1ns/100ps

module alu (
	input  coreCtrlPkg::aluOpT           op,
	input  logic [isaPkg::dataWidth-1:0] a,       // rs
	input  logic [isaPkg::dataWidth-1:0] b,       // rt or extended immediate
	input  logic [4:0]                   shamt,
	output logic [isaPkg::dataWidth-1:0] result,
	output logic                         zero
);

	logic lessThan;     // signed a < b
	logic greaterThan;  // signed a > b

	assign lessThan    = $signed(a) < $signed(b);
	assign greaterThan = $signed(a) > $signed(b);

	always_comb begin
		case (op)
			coreCtrlPkg::aluAdd: result = a + b;  // no overflow trap
			coreCtrlPkg::aluSub: result = a - b;
			coreCtrlPkg::aluAnd: result = a & b;
			coreCtrlPkg::aluOr:  result = a | b;
			coreCtrlPkg::aluXor: result = a ^ b;
			coreCtrlPkg::aluNor: result = ~(a | b);
			coreCtrlPkg::aluSlt: begin
				result = '0;
				result[0] = lessThan;
			end
			coreCtrlPkg::aluSgt: begin
				result = '0;
				result[0] = greaterThan;
			end
			coreCtrlPkg::aluSll: result = b << shamt;  // shifts ignore a
			coreCtrlPkg::aluSrl: result = b >> shamt;  // logical, zero fill
			default:             result = '0;
		endcase
	end

	assign zero = (result == '0);  // beq equality test

endmodule

//--- src/controlUnit.sv
`timescale 1ns/100ps

module controlUnit (
	input  isaPkg::instrWord     instr,
	input  logic                 rst,
	output coreCtrlPkg::ctrlWord ctrl
);

	isaPkg::opcodeT opcode;
	isaPkg::functT  funct;

	assign opcode = instr.rFmt.opcode;
	assign funct  = instr.rFmt.funct;  // only meaningful for RType

	always_comb begin
		ctrl = '0;  // unknown opcodes fall through as no-ops
		if (rst) begin
			case (opcode)
				isaPkg::hltInst: begin
					ctrl.hlt = 1'b1;
				end

				isaPkg::RType: begin
					ctrl.regDst     = 1'b1;  // result goes to rd
					ctrl.regWriteEn = 1'b1;
					case (funct)
						isaPkg::add, isaPkg::addu: ctrl.aluOp = coreCtrlPkg::aluAdd;
						isaPkg::sub, isaPkg::subu: ctrl.aluOp = coreCtrlPkg::aluSub;
						isaPkg::andF: ctrl.aluOp = coreCtrlPkg::aluAnd;
						isaPkg::orF:  ctrl.aluOp = coreCtrlPkg::aluOr;
						isaPkg::xorF: ctrl.aluOp = coreCtrlPkg::aluXor;
						isaPkg::norF: ctrl.aluOp = coreCtrlPkg::aluNor;
						isaPkg::slt:  ctrl.aluOp = coreCtrlPkg::aluSlt;
						isaPkg::sgt:  ctrl.aluOp = coreCtrlPkg::aluSgt;
						isaPkg::sll:  ctrl.aluOp = coreCtrlPkg::aluSll;  // shifts rt by shamt
						isaPkg::srl:  ctrl.aluOp = coreCtrlPkg::aluSrl;
						isaPkg::jr: begin
							ctrl.regDst     = 1'b0;
							ctrl.regWriteEn = 1'b0;  // jr writes no register
							ctrl.jumpReg    = 1'b1;
						end
						default: begin
							ctrl.regDst     = 1'b0;  // unknown funct is a no-op too
							ctrl.regWriteEn = 1'b0;
						end
					endcase
				end

				isaPkg::j: begin
					ctrl.jump = 1'b1;
				end

				isaPkg::jal: begin
					ctrl.jump       = 1'b1;
					ctrl.link       = 1'b1;  // r31 gets pc+1
					ctrl.regDst     = 1'b1;
					ctrl.regWriteEn = 1'b1;
				end

				isaPkg::beq: begin
					ctrl.branch = 1'b1;
					ctrl.aluOp  = coreCtrlPkg::aluSub;  // zero flag means equal
				end

				isaPkg::addi: begin
					ctrl.regWriteEn = 1'b1;  // to rt
					ctrl.aluSrc     = 1'b1;
				end

				isaPkg::slti: begin
					ctrl.regWriteEn = 1'b1;
					ctrl.aluSrc     = 1'b1;
					ctrl.aluOp      = coreCtrlPkg::aluSlt;
				end

				isaPkg::andi, isaPkg::ori, isaPkg::xori: begin
					ctrl.regWriteEn = 1'b1;
					ctrl.aluSrc     = 1'b1;
					ctrl.zeroExt    = 1'b1;  // logic immediates are unsigned
					if (opcode == isaPkg::andi) ctrl.aluOp = coreCtrlPkg::aluAnd;
					else if (opcode == isaPkg::ori) ctrl.aluOp = coreCtrlPkg::aluOr;
					else ctrl.aluOp = coreCtrlPkg::aluXor;
				end

				isaPkg::lw: begin
					ctrl.memReadEn  = 1'b1;
					ctrl.memToReg   = 1'b1;
					ctrl.regWriteEn = 1'b1;
					ctrl.aluSrc     = 1'b1;  // address is rs + imm
				end

				isaPkg::sw: begin
					ctrl.memWriteEn = 1'b1;
					ctrl.aluSrc     = 1'b1;
				end

				default: ;
			endcase
		end
	end

endmodule

//--- src/coreCtrlPkg.sv
package coreCtrlPkg;

	localparam int dmemWords     = 64;  // data memory depth in words
	localparam int dmemAddrWidth = 6;   // log2 of dmemWords

	// ALU operation codes, same numbering as the original control unit
	typedef enum logic [3:0] {
		aluAdd = 4'd0,
		aluSub = 4'd1,
		aluAnd = 4'd2,
		aluOr  = 4'd3,
		aluXor = 4'd4,
		aluNor = 4'd5,
		aluSlt = 4'd6,
		aluSgt = 4'd7,
		aluSll = 4'd8,
		aluSrl = 4'd9
	} aluOpT;

	typedef struct packed {
		logic  regDst;      // write rd instead of rt
		logic  link;        // jal, write pc+1 to r31
		logic  memReadEn;   // load from data memory
		logic  memToReg;    // write-back takes memory data
		logic  memWriteEn;  // store to data memory
		logic  regWriteEn;  // register file write
		logic  aluSrc;      // ALU b operand is the immediate
		logic  zeroExt;     // zero-extend imm16 for logic immediates
		logic  branch;      // beq
		logic  jump;        // j and jal
		logic  jumpReg;     // jr
		logic  hlt;         // halt the core
		aluOpT aluOp;
	} ctrlWord;

	// what the instruction at the pc does when it commits
	typedef struct packed {
		logic [isaPkg::pcWidth-1:0]   pc;
		logic                         regWrite;
		isaPkg::regAddr               regDst;
		logic [isaPkg::dataWidth-1:0] regData;
		logic                         memWrite;
		logic [dmemAddrWidth-1:0]     memAddr;
		logic [isaPkg::dataWidth-1:0] memData;
	} retireInfo;

endpackage

//--- src/fetchUnit.sv
`timescale 1ns/100ps

module fetchUnit (
	input  logic                         clk,
	input  logic                         rst,
	input  isaPkg::instrWord             instr,
	input  coreCtrlPkg::ctrlWord         ctrl,
	input  logic                         zero,    // ALU result of rs-rt was 0
	input  logic [isaPkg::dataWidth-1:0] rsData,  // jr target
	output logic [isaPkg::pcWidth-1:0]   pc,
	output logic                         halted
);

	logic [isaPkg::pcWidth-1:0] pcInc;     // sequential successor
	logic [isaPkg::pcWidth-1:0] brOffset;  // imm16 cut to pc width
	logic [isaPkg::pcWidth-1:0] brTarget;
	logic [isaPkg::pcWidth-1:0] nextPc;

	assign pcInc    = pc + 1'b1;
	assign brOffset = instr.iFmt.imm16[isaPkg::pcWidth-1:0];  // sign bits above wrap away
	assign brTarget = pcInc + brOffset;  // relative to the following instruction

	// no delay slot, the chosen target is fetched right after this commit
	always_comb begin
		if (ctrl.hlt) begin
			nextPc = pc;  // hlt leaves the pc on itself
		end else if (ctrl.jumpReg) begin
			nextPc = rsData[isaPkg::pcWidth-1:0];
		end else if (ctrl.jump) begin
			nextPc = instr.jFmt.target26[isaPkg::pcWidth-1:0];
		end else if (ctrl.branch && zero) begin
			nextPc = brTarget;  // beq taken
		end else begin
			nextPc = pcInc;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			pc     <= '0;
			halted <= 1'b0;
		end else if (!halted) begin  // frozen once halted, until reset
			pc     <= nextPc;
			halted <= ctrl.hlt;
		end
	end

endmodule

//--- src/isaPkg.sv
package isaPkg;

	localparam int dataWidth = 32;  // architectural word size
	localparam int pcWidth   = 8;   // program memory is 256 words
	localparam int regCount  = 32;  // general purpose registers

	typedef logic [4:0] regAddr;  // register specifier

	// primary opcode, bits 31:26
	typedef enum logic [5:0] {
		RType   = 6'd0,   // funct selects the operation
		j       = 6'd2,
		jal     = 6'd3,
		beq     = 6'd4,
		addi    = 6'd8,
		slti    = 6'd10,
		andi    = 6'd12,
		ori     = 6'd13,
		xori    = 6'd14,
		lw      = 6'd35,
		sw      = 6'd43,
		hltInst = 6'd63   // stops the core until reset
	} opcodeT;

	// R-type function field, bits 5:0
	typedef enum logic [5:0] {
		sll  = 6'd0,
		srl  = 6'd2,
		jr   = 6'd8,
		add  = 6'd32,
		addu = 6'd33,
		sub  = 6'd34,
		subu = 6'd35,
		andF = 6'd36,
		orF  = 6'd37,
		xorF = 6'd38,
		norF = 6'd39,
		slt  = 6'd42,
		sgt  = 6'd43  // nonstandard, kept from the original ISA
	} functT;

	typedef struct packed {
		opcodeT     opcode;
		regAddr     rs;
		regAddr     rt;
		regAddr     rd;
		logic [4:0] shamt;  // shift amount for sll and srl
		functT      funct;
	} rFormat;

	typedef struct packed {
		opcodeT      opcode;
		regAddr      rs;
		regAddr      rt;
		logic [15:0] imm16;  // extension depends on the opcode
	} iFormat;

	typedef struct packed {
		opcodeT      opcode;
		logic [25:0] target26;  // word index, only low pcWidth bits matter
	} jFormat;

	// one fetched word, read through whichever format the opcode implies
	typedef union packed {
		rFormat rFmt;
		iFormat iFmt;
		jFormat jFmt;
	} instrWord;

endpackage

//--- src/memStage.sv
`timescale 1ns/100ps

module memStage (
	input  logic                                clk,
	input  coreCtrlPkg::ctrlWord                ctrl,
	input  logic                                halted,
	input  logic [isaPkg::dataWidth-1:0]        aluResult,  // word address for lw and sw
	input  logic [isaPkg::dataWidth-1:0]        rtData,     // store data
	input  logic [isaPkg::pcWidth-1:0]          linkPc,     // pc+1 for jal
	input  isaPkg::regAddr                      rt,
	input  isaPkg::regAddr                      rd,
	output isaPkg::regAddr                      wbAddr,
	output logic [isaPkg::dataWidth-1:0]        wbData,
	output logic                                wbEn
);

	logic [isaPkg::dataWidth-1:0]         dmem [coreCtrlPkg::dmemWords];
	logic [coreCtrlPkg::dmemAddrWidth-1:0] addr;
	logic [isaPkg::dataWidth-1:0]         rdData;

	assign addr   = aluResult[coreCtrlPkg::dmemAddrWidth-1:0];  // upper bits wrap
	assign rdData = ctrl.memReadEn ? dmem[addr] : '0;  // asynchronous read

	always_ff @(posedge clk) begin
		if (ctrl.memWriteEn && !halted) begin
			dmem[addr] <= rtData;
		end
	end

	always_comb begin
		if (ctrl.link) begin
			wbAddr = 5'd31;  // return address register
			wbData = {{(isaPkg::dataWidth-isaPkg::pcWidth){1'b0}}, linkPc};
		end else begin
			wbAddr = ctrl.regDst ? rd : rt;
			wbData = ctrl.memToReg ? rdData : aluResult;
		end
	end

	assign wbEn = ctrl.regWriteEn && !halted;  // nothing retires after hlt

endmodule

//--- src/mipsCore.sv
`timescale 1ns/100ps

module mipsCore (
	input  logic                       clk,
	input  logic                       rst,
	output logic [isaPkg::pcWidth-1:0] imemAddr,
	input  isaPkg::instrWord           imemData,  // combinational from program memory
	output coreCtrlPkg::retireInfo     retire,
	output logic                       halted
);

	coreCtrlPkg::ctrlWord         ctrl;
	logic [isaPkg::pcWidth-1:0]   pc;
	logic [isaPkg::dataWidth-1:0] rsData;
	logic [isaPkg::dataWidth-1:0] rtData;
	logic [isaPkg::dataWidth-1:0] immExt;  // imm16 widened per opcode
	logic [isaPkg::dataWidth-1:0] aluB;
	logic [isaPkg::dataWidth-1:0] aluResult;
	logic                         zero;
	isaPkg::regAddr               wbAddr;
	logic [isaPkg::dataWidth-1:0] wbData;
	logic                         wbEn;

	assign imemAddr = pc;

	assign immExt = ctrl.zeroExt
		? {{(isaPkg::dataWidth-16){1'b0}}, imemData.iFmt.imm16}
		: {{(isaPkg::dataWidth-16){imemData.iFmt.imm16[15]}}, imemData.iFmt.imm16};
	assign aluB = ctrl.aluSrc ? immExt : rtData;

	fetchUnit i_fetch (
		.clk    (clk),
		.rst    (rst),
		.instr  (imemData),
		.ctrl   (ctrl),
		.zero   (zero),
		.rsData (rsData),
		.pc     (pc),
		.halted (halted)
	);

	controlUnit i_ctrl (
		.instr (imemData),
		.rst   (rst),
		.ctrl  (ctrl)
	);

	regFile i_regs (
		.clk    (clk),
		.rst    (rst),
		.rsAddr (imemData.rFmt.rs),
		.rtAddr (imemData.rFmt.rt),
		.rsData (rsData),
		.rtData (rtData),
		.we     (wbEn),
		.wAddr  (wbAddr),
		.wData  (wbData)
	);

	alu i_alu (
		.op     (ctrl.aluOp),
		.a      (rsData),
		.b      (aluB),
		.shamt  (imemData.rFmt.shamt),
		.result (aluResult),
		.zero   (zero)
	);

	memStage i_mem (
		.clk       (clk),
		.ctrl      (ctrl),
		.halted    (halted),
		.aluResult (aluResult),
		.rtData    (rtData),
		.linkPc    (pc + 1'b1),  // jal return address
		.rt        (imemData.rFmt.rt),
		.rd        (imemData.rFmt.rd),
		.wbAddr    (wbAddr),
		.wbData    (wbData),
		.wbEn      (wbEn)
	);

	// describes the instruction at the pc, committed on the next edge
	assign retire.pc       = pc;
	assign retire.regWrite = wbEn;  // r0 writes still show here
	assign retire.regDst   = wbAddr;
	assign retire.regData  = wbData;
	assign retire.memWrite = ctrl.memWriteEn && !halted;
	assign retire.memAddr  = aluResult[coreCtrlPkg::dmemAddrWidth-1:0];
	assign retire.memData  = rtData;

endmodule

//--- src/regFile.sv
`timescale 1ns/100ps

module regFile (
	input  logic                         clk,
	input  logic                         rst,
	input  isaPkg::regAddr               rsAddr,
	input  isaPkg::regAddr               rtAddr,
	output logic [isaPkg::dataWidth-1:0] rsData,
	output logic [isaPkg::dataWidth-1:0] rtData,
	input  logic                         we,
	input  isaPkg::regAddr               wAddr,
	input  logic [isaPkg::dataWidth-1:0] wData
);

	logic [isaPkg::dataWidth-1:0] regs [isaPkg::regCount];

	// r0 is hardwired, whatever was written there never shows
	assign rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
	assign rtData = (rtAddr == '0) ? '0 : regs[rtAddr];

	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int k = 0; k < isaPkg::regCount; k++) begin
				regs[k] <= '0;  // whole file starts clean
			end
		end else if (we) begin
			regs[wAddr] <= wData;  // new value visible next cycle
		end
	end

endmodule

//--- tb/tbCore.sv
`timescale 1ns/100ps

module tbCore;

	localparam int runLimit = 300;  // cycles one program may take to reach hlt

	logic                         clk;
	logic                         rst;
	logic [isaPkg::pcWidth-1:0]   imemAddr;
	isaPkg::instrWord             imemData;
	coreCtrlPkg::retireInfo       retire;
	logic                         halted;

	isaPkg::instrWord             prog [2**isaPkg::pcWidth];  // program memory model
	int                           progLen;
	logic [31:0]                  mRegs [32];  // ISA model state
	logic [31:0]                  mDmem [coreCtrlPkg::dmemWords];
	logic [isaPkg::pcWidth-1:0]   mPc;
	logic                         mHalted;
	logic [31:0]                  sig;  // folds every retire of one run
	logic [31:0]                  rngState;
	int                           retireErrs;
	int                           haltErrs;
	int                           valueErrs;
	int                           timeouts;

	mipsCore i_dut (
		.clk      (clk),
		.rst      (rst),
		.imemAddr (imemAddr),
		.imemData (imemData),
		.retire   (retire),
		.halted   (halted)
	);

	always #10 clk = ~clk;
	always @(negedge clk) imemData <= prog[imemAddr];  // fetch for the current pc

	function automatic isaPkg::instrWord rIns(isaPkg::functT f, int rd, int rs, int rt, int sh);
		return {isaPkg::RType, 5'(rs), 5'(rt), 5'(rd), 5'(sh), f};
	endfunction

	function automatic isaPkg::instrWord iIns(isaPkg::opcodeT op, int rt, int rs,
			logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic isaPkg::instrWord jIns(isaPkg::opcodeT op, int target);
		return {op, 26'(target)};
	endfunction

	function automatic logic [31:0] xorshift();
		logic [31:0] x;
		x = rngState;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rngState = x;
		return x;
	endfunction

	task automatic emit(input isaPkg::instrWord w);
		prog[progLen] = w;
		progLen++;
	endtask

	task automatic clearProg();
		for (int a = 0; a < 2**isaPkg::pcWidth; a++) begin
			prog[a] = {isaPkg::hltInst, 18'd0, 8'(a)};  // stray fetch halts, address in low bits
		end
		progLen = 0;
	endtask

	// full 32-bit constant from addi, sll 16 and ori
	task automatic loadReg(input int r, input logic [31:0] value);
		emit(iIns(isaPkg::addi, r, 0, value[31:16]));
		emit(rIns(isaPkg::sll, r, 0, r, 16));
		emit(iIns(isaPkg::ori, r, r, value[15:0]));
	endtask

	task automatic checkRetire(input coreCtrlPkg::retireInfo got,
			input coreCtrlPkg::retireInfo exp);
		logic bad;
		bad = (got.pc !== exp.pc) || (got.regWrite !== exp.regWrite)
			|| (got.memWrite !== exp.memWrite);
		if (exp.regWrite && (got.regDst !== exp.regDst || got.regData !== exp.regData)) bad = 1'b1;
		if (exp.memWrite && (got.memAddr !== exp.memAddr || got.memData !== exp.memData)) bad = 1'b1;
		if (bad) begin
			retireErrs++;
			$display("Error at %0t: retire pc %0d wr %b r%0d=%h mw %b [%0d]=%h", $time, got.pc,
				got.regWrite, got.regDst, got.regData, got.memWrite, got.memAddr, got.memData);
			$display("  expected pc %0d wr %b r%0d=%h mw %b [%0d]=%h", exp.pc, exp.regWrite,
				exp.regDst, exp.regData, exp.memWrite, exp.memAddr, exp.memData);
		end
	endtask

	task automatic checkHalt(input logic got, input logic exp);
		if (got !== exp) begin
			haltErrs++;
			$display("Error at %0t: halted is %b, expected %b", $time, got, exp);
		end
	endtask

	task automatic checkWord(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			valueErrs++;
			$display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// ISA model: what the instruction at mPc should retire, and where it leads
	task automatic predict(output coreCtrlPkg::retireInfo e, output logic [7:0] nPc,
			output logic nHlt);
		isaPkg::instrWord w;
		logic [31:0]      rs;
		logic [31:0]      rt;
		logic [31:0]      sImm;
		logic [31:0]      ea;
		w    = prog[mPc];
		rs   = mRegs[w.rFmt.rs];
		rt   = mRegs[w.rFmt.rt];
		sImm = {{16{w.iFmt.imm16[15]}}, w.iFmt.imm16};
		ea   = rs + sImm;  // lw and sw word index
		e    = '0;
		e.pc = mPc;
		e.regDst   = w.rFmt.rt;
		e.regWrite = 1'b1;  // cleared below where nothing is written
		nPc  = mPc + 1'b1;
		nHlt = 1'b0;
		case (w.rFmt.opcode)
			isaPkg::RType: begin
				e.regDst = w.rFmt.rd;
				case (w.rFmt.funct)
					isaPkg::add, isaPkg::addu: e.regData = rs + rt;
					isaPkg::sub, isaPkg::subu: e.regData = rs - rt;
					isaPkg::andF: e.regData = rs & rt;
					isaPkg::orF:  e.regData = rs | rt;
					isaPkg::xorF: e.regData = rs ^ rt;
					isaPkg::norF: e.regData = ~(rs | rt);
					isaPkg::slt:  e.regData = {31'd0, $signed(rs) < $signed(rt)};
					isaPkg::sgt:  e.regData = {31'd0, $signed(rs) > $signed(rt)};
					isaPkg::sll:  e.regData = rt << w.rFmt.shamt;
					isaPkg::srl:  e.regData = rt >> w.rFmt.shamt;
					isaPkg::jr: begin
						e.regWrite = 1'b0;
						nPc = rs[7:0];
					end
					default: e.regWrite = 1'b0;
				endcase
			end
			isaPkg::j: begin
				e.regWrite = 1'b0;
				nPc = w.jFmt.target26[7:0];
			end
			isaPkg::jal: begin
				e.regDst  = 5'd31;
				e.regData = {24'd0, nPc};  // link taken before the jump
				nPc = w.jFmt.target26[7:0];
			end
			isaPkg::beq: begin
				e.regWrite = 1'b0;
				if (rs == rt) nPc = nPc + sImm[7:0];
			end
			isaPkg::addi: e.regData = rs + sImm;
			isaPkg::slti: e.regData = {31'd0, $signed(rs) < $signed(sImm)};
			isaPkg::andi: e.regData = rs & {16'd0, w.iFmt.imm16};
			isaPkg::ori:  e.regData = rs | {16'd0, w.iFmt.imm16};
			isaPkg::xori: e.regData = rs ^ {16'd0, w.iFmt.imm16};
			isaPkg::lw:   e.regData = mDmem[ea[5:0]];
			isaPkg::sw: begin
				e.regWrite = 1'b0;
				e.memWrite = 1'b1;
				e.memAddr  = ea[5:0];
				e.memData  = rt;
			end
			isaPkg::hltInst: begin
				e.regWrite = 1'b0;
				nPc  = mPc;  // pc stays on the hlt
				nHlt = 1'b1;
			end
			default: e.regWrite = 1'b0;
		endcase
	endtask

	// compares before the edge, then commits the model alongside the core
	always @(posedge clk) begin : modelStep
		coreCtrlPkg::retireInfo     e;
		logic [isaPkg::pcWidth-1:0] nPc;
		logic                       nHlt;
		if (!rst) begin
			mPc     = '0;
			mHalted = 1'b0;
			for (int k = 0; k < 32; k++) mRegs[k] = '0;
		end else begin
			checkHalt(halted, mHalted);
			if (mHalted) begin
				e    = '0;  // frozen pc, no writes
				e.pc = mPc;
				checkRetire(retire, e);
			end else begin
				predict(e, nPc, nHlt);
				checkRetire(retire, e);
				sig = {sig[30:0], sig[31]} ^ {24'd0, retire.pc}
					^ (retire.regWrite ? retire.regData : 32'd0);
				if (e.regWrite && e.regDst != 5'd0) mRegs[e.regDst] = e.regData;  // r0 stays 0
				if (e.memWrite) mDmem[e.memAddr] = e.memData;
				mPc     = nPc;
				mHalted = nHlt;
			end
		end
	end

	task automatic resetCore();
		@(negedge clk);
		rst = 1'b0;
		sig = '0;
		repeat (8) @(negedge clk);
		rst = 1'b1;
	endtask

	task automatic runProgram();
		int cycles;
		resetCore();
		cycles = 0;
		while (!halted && cycles < runLimit) begin
			@(negedge clk);
			cycles++;
		end
		if (!halted) begin
			timeouts++;
			$display("Timeout: the core did not halt within %0d cycles", runLimit);
		end
	endtask

	task automatic testAluOps();
		isaPkg::functT ops [10];
		ops = '{isaPkg::add, isaPkg::addu, isaPkg::sub, isaPkg::subu, isaPkg::andF,
			isaPkg::orF, isaPkg::xorF, isaPkg::norF, isaPkg::slt, isaPkg::sgt};
		clearProg();
		loadReg(1, xorshift());
		loadReg(2, xorshift());
		loadReg(3, xorshift() | 32'h8000_0000);  // negative
		loadReg(4, xorshift() & 32'h7fff_ffff);  // positive, signed compare differs from unsigned
		for (int i = 0; i < 10; i++) emit(rIns(ops[i], 8 + i, 1, 2, 0));
		emit(rIns(isaPkg::slt, 18, 3, 4, 0));
		emit(rIns(isaPkg::sgt, 19, 3, 4, 0));
		emit(rIns(isaPkg::slt, 20, 4, 3, 0));
		emit(rIns(isaPkg::sgt, 21, 4, 3, 0));
		emit(rIns(isaPkg::slt, 22, 1, 1, 0));  // equal operands
		emit(jIns(isaPkg::hltInst, 0));
		runProgram();
	endtask

	task automatic testImmediates();
		clearProg();
		loadReg(1, xorshift());
		emit(iIns(isaPkg::addi, 2, 1, 16'hff80));
		emit(iIns(isaPkg::slti, 3, 1, 16'h8000));
		emit(iIns(isaPkg::addi, 4, 0, 16'hffff));  // r4 = -1
		emit(iIns(isaPkg::slti, 5, 4, 16'hfffe));
		emit(iIns(isaPkg::slti, 6, 4, 16'h0001));
		emit(iIns(isaPkg::andi, 7, 1, 16'hf0f0));
		emit(iIns(isaPkg::ori, 8, 0, 16'h8001));
		emit(iIns(isaPkg::xori, 9, 4, 16'hffff));
		emit(iIns(isaPkg::addi, 0, 1, 16'd5));  // r0 write still retires
		emit(rIns(isaPkg::addu, 10, 0, 0, 0));  // and r0 reads back 0
		emit(jIns(isaPkg::hltInst, 0));
		runProgram();
	endtask

	task automatic testShifts();
		clearProg();
		loadReg(1, xorshift());
		for (int i = 0; i < 4; i++) begin
			emit(rIns(isaPkg::sll, 2 + i, 0, 1, 5'(xorshift())));
			emit(rIns(isaPkg::srl, 6 + i, 0, 1, 5'(xorshift())));
		end
		emit(jIns(isaPkg::hltInst, 0));
		runProgram();
	endtask

	task automatic testMemory();
		logic [15:0] offs [4];
		offs = '{16'd3, 16'd7, 16'hffff, 16'd20};  // -1 checks the signed offset
		clearProg();
		loadReg(1, (xorshift() & 32'hf) + 32'd8);  // base keeps every address in range
		for (int i = 0; i < 4; i++) loadReg(2 + i, xorshift());
		for (int i = 0; i < 4; i++) emit(iIns(isaPkg::sw, 2 + i, 1, offs[i]));
		for (int i = 3; i >= 0; i--) emit(iIns(isaPkg::lw, 10 + i, 1, offs[i]));
		emit(iIns(isaPkg::sw, 5, 1, offs[0]));  // overwrite, then load again
		emit(iIns(isaPkg::lw, 14, 1, offs[0]));
		emit(jIns(isaPkg::hltInst, 0));
		runProgram();
	endtask

	task automatic testControlFlow();
		clearProg();
		emit(iIns(isaPkg::addi, 1, 0, 16'd5));      // 0
		emit(iIns(isaPkg::addi, 2, 0, 16'd5));      // 1
		emit(iIns(isaPkg::beq, 2, 1, 16'd2));       // 2 taken to 5
		emit(iIns(isaPkg::addi, 3, 0, 16'd1));      // 3 skipped
		emit(iIns(isaPkg::addi, 3, 0, 16'd2));      // 4 skipped
		emit(iIns(isaPkg::beq, 0, 1, 16'd1));       // 5 not taken
		emit(jIns(isaPkg::jal, 10));                // 6 r31 = 7
		emit(iIns(isaPkg::addi, 5, 0, 16'd7));      // 7 return lands here
		emit(jIns(isaPkg::j, 13));                  // 8
		emit(iIns(isaPkg::addi, 6, 0, 16'd9));      // 9 skipped
		emit(iIns(isaPkg::addi, 4, 0, 16'd3));      // 10 subroutine
		emit(rIns(isaPkg::jr, 0, 31, 0, 0));        // 11
		emit(iIns(isaPkg::addi, 6, 0, 16'd12));     // 12 skipped
		emit(iIns(isaPkg::addi, 2, 2, 16'hffff));   // 13 count down
		emit(iIns(isaPkg::beq, 0, 2, 16'd1));       // 14 exit at zero
		emit(iIns(isaPkg::beq, 0, 0, 16'hfffd));    // 15 backward to 13
		emit(jIns(isaPkg::hltInst, 0));             // 16
		runProgram();
	endtask

	task automatic testHaltReset();
		logic [31:0] firstSig;
		clearProg();
		loadReg(1, xorshift());
		loadReg(2, xorshift());
		emit(rIns(isaPkg::xorF, 3, 1, 2, 0));
		emit(iIns(isaPkg::sw, 3, 0, 16'd40));
		emit(iIns(isaPkg::lw, 4, 0, 16'd40));
		emit(jIns(isaPkg::hltInst, 0));
		runProgram();
		firstSig = sig;
		repeat (20) @(negedge clk);  // model expects a frozen pc and no writes
		checkHalt(halted, 1'b1);
		resetCore();
		checkHalt(halted, 1'b0);
		checkWord({24'd0, imemAddr}, 32'd0, "pc after reset");
		runProgram();
		checkWord(sig, firstSig, "rerun signature");
	endtask

	initial begin
		clk        = 1'b0;
		rst        = 1'b0;
		imemData   = '0;
		rngState   = 32'h1faadf48;
		sig        = '0;
		mPc        = '0;
		mHalted    = 1'b0;
		retireErrs = 0;
		haltErrs   = 0;
		valueErrs  = 0;
		timeouts   = 0;
		for (int k = 0; k < coreCtrlPkg::dmemWords; k++) mDmem[k] = '0;
		testAluOps();
		testImmediates();
		testShifts();
		testMemory();
		testControlFlow();
		testHaltReset();
		$display("Errors: retire %0d, halt %0d, value %0d, timeout %0d",
			retireErrs, haltErrs, valueErrs, timeouts);
		if (retireErrs + haltErrs + valueErrs + timeouts == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
